//--- logic/support_pkg.sv
package support_pkg;

  // ##########################################################################
  // widths
  // ##########################################################################

  localparam int RBUS_ADDR_BITS = 20;
  localparam int RBUS_DATA_BITS = 32;
  localparam int LOCL_ADDR_BITS = 8;   // byte offset, word aligned.

  localparam int N_IM_ENGINES = 9;
  localparam int IM_BITS      = 2 * N_IM_ENGINES;
  localparam int INT0_BITS    = 15;
  localparam int INT1_BITS    = 7;
  localparam int DF_MUX_BITS  = 2;

  localparam logic [15:0] BLKID = 16'h0c64;
  localparam logic [15:0] REVID = 16'h0001;
  localparam logic [RBUS_DATA_BITS-1:0] BLKID_REVID = {BLKID, REVID};

  // ##########################################################################
  // register map
  // ##########################################################################

  typedef enum logic [LOCL_ADDR_BITS-1:0] {
    REG_BLKID_REVID  = 8'h00,
    REG_CTL          = 8'h04,
    REG_DF_MUX_CTRL  = 8'h08,
    REG_IM_AVAILABLE = 8'h0C,
    REG_IM_CONSUMED  = 8'h10,
    REG_PIPE_STAT    = 8'h14,
    REG_INT0_STATUS  = 8'h18,
    REG_INT0_MASK    = 8'h1C,
    REG_INT1_STATUS  = 8'h20,
    REG_INT1_MASK    = 8'h24
  } reg_addr_e;

  // ##########################################################################
  // bus and bank types
  // ##########################################################################

  typedef struct packed {
    logic [RBUS_ADDR_BITS-1:0] addr;
    logic                      wr_strb;
    logic [RBUS_DATA_BITS-1:0] wr_data;
    logic                      rd_strb;
    logic [RBUS_DATA_BITS-1:0] rd_data;
    logic                      ack;
    logic                      err_ack;
  } rbus_t;

  typedef struct packed {
    logic [LOCL_ADDR_BITS-1:0] addr;
    logic                      wr_strb;
    logic                      rd_strb;
    logic [RBUS_DATA_BITS-1:0] wr_data;
  } locl_req_t;

  typedef struct packed {
    logic [RBUS_DATA_BITS-1:0] rd_data;
    logic                      ack;
    logic                      err_ack;
  } locl_rsp_t;

  typedef struct packed {
    logic bank_hi;
    logic bank_lo;
  } im_bank_t;

  // engine 0 (lz77 compress) sits in the low bits.
  typedef im_bank_t [N_IM_ENGINES-1:0] im_banks_t;

endpackage

//--- logic/rbus_node.sv
`timescale 1ns/1ps

module rbus_node (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  support_pkg::rbus_t                      i_rbus,
  input  logic [support_pkg::RBUS_ADDR_BITS-1:0]  i_cfg_start_addr,
  input  logic [support_pkg::RBUS_ADDR_BITS-1:0]  i_cfg_end_addr,
  input  support_pkg::locl_rsp_t                  i_locl_rsp,
  output support_pkg::rbus_t                      o_rbus,
  output support_pkg::locl_req_t                  o_locl_req
);
  import support_pkg::*;

  logic                      in_window;
  logic                      rsp_valid;
  logic [RBUS_ADDR_BITS-1:0] out_addr;
  logic [RBUS_DATA_BITS-1:0] out_wr_data;
  logic [RBUS_DATA_BITS-1:0] out_rd_data;
  logic                      out_wr_strb;
  logic                      out_rd_strb;
  logic                      out_ack;
  logic                      out_err_ack;
  logic [LOCL_ADDR_BITS-1:0] req_addr;
  logic [RBUS_DATA_BITS-1:0] req_wr_data;
  logic                      req_wr_strb;
  logic                      req_rd_strb;

  assign in_window = (i_rbus.addr >= i_cfg_start_addr) && (i_rbus.addr <= i_cfg_end_addr);
  assign rsp_valid = i_locl_rsp.ack || i_locl_rsp.err_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_wr_strb <= 1'b0;
      out_rd_strb <= 1'b0;
      out_ack     <= 1'b0;
      out_err_ack <= 1'b0;
      req_wr_strb <= 1'b0;
      req_rd_strb <= 1'b0;
    end else begin
      out_wr_strb <= i_rbus.wr_strb && !in_window;   // claimed accesses leave the ring.
      out_rd_strb <= i_rbus.rd_strb && !in_window;
      out_ack     <= i_rbus.ack || i_locl_rsp.ack;
      out_err_ack <= i_rbus.err_ack || i_locl_rsp.err_ack;
      req_wr_strb <= i_rbus.wr_strb && in_window;
      req_rd_strb <= i_rbus.rd_strb && in_window;
    end
  end

  always_ff @(posedge clk) begin
    out_addr    <= i_rbus.addr;
    out_wr_data <= i_rbus.wr_data;
    out_rd_data <= rsp_valid ? i_locl_rsp.rd_data : i_rbus.rd_data;
    req_addr    <= i_rbus.addr[LOCL_ADDR_BITS-1:0];
    req_wr_data <= i_rbus.wr_data;
  end

  assign o_rbus = '{addr:    out_addr,
                    wr_strb: out_wr_strb,
                    wr_data: out_wr_data,
                    rd_strb: out_rd_strb,
                    rd_data: out_rd_data,
                    ack:     out_ack,
                    err_ack: out_err_ack};

  assign o_locl_req = '{addr:    req_addr,
                        wr_strb: req_wr_strb,
                        rd_strb: req_rd_strb,
                        wr_data: req_wr_data};

  a_rsp_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    !(i_locl_rsp.ack && i_locl_rsp.err_ack));

endmodule

//--- logic/event_interrupt.sv
`timescale 1ns/1ps

module event_interrupt #(
  parameter int N_INT_BITS = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [N_INT_BITS-1:0] i_event,
  input  logic                  i_rd_status,
  input  logic                  i_wr_status,
  input  logic                  i_wr_mask,
  input  logic [N_INT_BITS-1:0] i_wr_data,
  output logic [N_INT_BITS-1:0] o_status,
  output logic [N_INT_BITS-1:0] o_mask,
  output logic                  o_int
);

  logic [N_INT_BITS-1:0] clr;
  logic [N_INT_BITS-1:0] status_nxt;

  assign clr        = i_wr_status ? i_wr_data : '0;
  assign status_nxt = (o_status & ~clr) | i_event;   // new event beats the clear.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_status <= '0;
      o_mask   <= '0;
      o_int    <= 1'b0;
    end else begin
      o_status <= status_nxt;
      if (i_wr_mask) begin
        o_mask <= i_wr_data;
      end
      o_int <= |(o_status & o_mask);
    end
  end

  // strobes come from one decoded register access.
  a_strb_excl : assert property (@(posedge clk) disable iff (!rst_n)
    i_rd_status |-> !(i_wr_status || i_wr_mask));

  // an enabled event raises o_int two cycles later.
  a_int_raise : assert property (@(posedge clk) disable iff (!rst_n)
    $past(|(i_event & o_mask) && !i_wr_mask, 2) |-> o_int);

endmodule

//--- logic/im_bank_ctrl.sv
`timescale 1ns/1ps

module im_bank_ctrl (
  input  logic                             clk,
  input  logic                             rst_n,
  input  support_pkg::im_banks_t           i_im_available,
  input  logic                             i_consumed_wr,
  input  logic [support_pkg::IM_BITS-1:0]  i_wr_data,
  output support_pkg::im_banks_t           o_available,
  output support_pkg::im_banks_t           o_im_consumed
);
  import support_pkg::*;

  im_banks_t consumed_nxt;

  assign consumed_nxt = i_consumed_wr ? im_banks_t'(i_wr_data) : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_available   <= '0;
      o_im_consumed <= '0;
    end else begin
      o_available   <= i_im_available;   // sampled for register reads.
      o_im_consumed <= consumed_nxt;     // single cycle pulse per write.
    end
  end

  // each write gives one pulse, never a run.
  a_consumed_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    (o_im_consumed != '0) |=> (o_im_consumed == '0));

endmodule

//--- logic/support_regfile.sv
`timescale 1ns/1ps

module support_regfile (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  support_pkg::locl_req_t                  i_locl_req,
  input  logic [support_pkg::RBUS_DATA_BITS-1:0]  i_pipe_stat,
  input  support_pkg::im_banks_t                  i_available,
  input  logic [support_pkg::INT0_BITS-1:0]       i_int0_status,
  input  logic [support_pkg::INT0_BITS-1:0]       i_int0_mask,
  input  logic [support_pkg::INT1_BITS-1:0]       i_int1_status,
  input  logic [support_pkg::INT1_BITS-1:0]       i_int1_mask,
  output support_pkg::locl_rsp_t                  o_locl_rsp,
  output logic [support_pkg::RBUS_DATA_BITS-1:0]  o_ctl_config,
  output logic [support_pkg::DF_MUX_BITS-1:0]     o_df_mux_sel,
  output logic                                    o_consumed_wr,
  output logic                                    o_int0_rd_status,
  output logic                                    o_int0_wr_status,
  output logic                                    o_int0_wr_mask,
  output logic                                    o_int1_rd_status,
  output logic                                    o_int1_wr_status,
  output logic                                    o_int1_wr_mask,
  output logic [support_pkg::RBUS_DATA_BITS-1:0]  o_wr_data
);
  import support_pkg::*;

  logic [RBUS_DATA_BITS-1:0] df_mux_ctrl;
  logic [RBUS_DATA_BITS-1:0] rd_data;
  logic [RBUS_DATA_BITS-1:0] rsp_rd_data;
  logic                      rsp_ack;
  logic                      rsp_err_ack;
  logic                      hit;
  logic                      writable;
  logic                      access;
  logic                      err;
  logic                      wr;
  logic                      rd;

  assign wr     = i_locl_req.wr_strb;
  assign rd     = i_locl_req.rd_strb;
  assign access = wr || rd;

  // ##########################################################################
  // decode and read mux
  // ##########################################################################

  always_comb begin
    rd_data  = '0;
    hit      = 1'b1;
    writable = 1'b0;
    case (i_locl_req.addr)
      REG_BLKID_REVID:  rd_data = BLKID_REVID;
      REG_CTL: begin
        rd_data  = o_ctl_config;
        writable = 1'b1;
      end
      REG_DF_MUX_CTRL: begin
        rd_data  = df_mux_ctrl;
        writable = 1'b1;
      end
      REG_IM_AVAILABLE: rd_data = RBUS_DATA_BITS'(i_available);
      REG_IM_CONSUMED:  writable = 1'b1;   // reads as zero.
      REG_PIPE_STAT:    rd_data = i_pipe_stat;
      REG_INT0_STATUS: begin
        rd_data  = RBUS_DATA_BITS'(i_int0_status);
        writable = 1'b1;
      end
      REG_INT0_MASK: begin
        rd_data  = RBUS_DATA_BITS'(i_int0_mask);
        writable = 1'b1;
      end
      REG_INT1_STATUS: begin
        rd_data  = RBUS_DATA_BITS'(i_int1_status);
        writable = 1'b1;
      end
      REG_INT1_MASK: begin
        rd_data  = RBUS_DATA_BITS'(i_int1_mask);
        writable = 1'b1;
      end
      default:          hit = 1'b0;
    endcase
  end

  assign err = !hit || (wr && !writable);

  // strobes to the bank and interrupt blocks.
  assign o_consumed_wr    = wr && (i_locl_req.addr == REG_IM_CONSUMED);
  assign o_int0_rd_status = rd && (i_locl_req.addr == REG_INT0_STATUS);
  assign o_int0_wr_status = wr && (i_locl_req.addr == REG_INT0_STATUS);
  assign o_int0_wr_mask   = wr && (i_locl_req.addr == REG_INT0_MASK);
  assign o_int1_rd_status = rd && (i_locl_req.addr == REG_INT1_STATUS);
  assign o_int1_wr_status = wr && (i_locl_req.addr == REG_INT1_STATUS);
  assign o_int1_wr_mask   = wr && (i_locl_req.addr == REG_INT1_MASK);
  assign o_wr_data        = i_locl_req.wr_data;

  // ##########################################################################
  // control registers and response
  // ##########################################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_ctl_config <= '0;
      df_mux_ctrl  <= '0;
      rsp_ack      <= 1'b0;
      rsp_err_ack  <= 1'b0;
    end else begin
      if (wr && (i_locl_req.addr == REG_CTL)) begin
        o_ctl_config <= i_locl_req.wr_data;
      end
      if (wr && (i_locl_req.addr == REG_DF_MUX_CTRL)) begin
        df_mux_ctrl <= i_locl_req.wr_data;
      end
      rsp_ack     <= access && !err;
      rsp_err_ack <= access && err;
    end
  end

  always_ff @(posedge clk) begin
    rsp_rd_data <= rd ? rd_data : '0;
  end

  assign o_df_mux_sel = df_mux_ctrl[DF_MUX_BITS-1:0];
  assign o_locl_rsp   = '{rd_data: rsp_rd_data, ack: rsp_ack, err_ack: rsp_err_ack};

  a_req_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(i_locl_req.rd_strb && i_locl_req.wr_strb));

endmodule

//--- logic/cceip_support.sv
`timescale 1ns/1ps

module cceip_support (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  support_pkg::rbus_t                      i_rbus,
  input  logic [support_pkg::RBUS_ADDR_BITS-1:0]  i_cfg_start_addr,
  input  logic [support_pkg::RBUS_ADDR_BITS-1:0]  i_cfg_end_addr,
  input  support_pkg::im_banks_t                  i_im_available,
  input  logic [support_pkg::RBUS_DATA_BITS-1:0]  i_pipe_stat,
  input  logic [support_pkg::INT0_BITS-1:0]       i_int0_event,
  input  logic [support_pkg::INT1_BITS-1:0]       i_int1_event,
  output support_pkg::rbus_t                      o_rbus,
  output support_pkg::im_banks_t                  o_im_consumed,
  output logic [support_pkg::RBUS_DATA_BITS-1:0]  o_ctl_config,
  output logic [support_pkg::DF_MUX_BITS-1:0]     o_df_mux_sel,
  output logic                                    o_int0,
  output logic                                    o_int1
);
  import support_pkg::*;

  locl_req_t                 locl_req;
  locl_rsp_t                 locl_rsp;
  im_banks_t                 available;
  logic [RBUS_DATA_BITS-1:0] wr_data;
  logic                      consumed_wr;
  logic                      int0_rd_status;
  logic                      int0_wr_status;
  logic                      int0_wr_mask;
  logic                      int1_rd_status;
  logic                      int1_wr_status;
  logic                      int1_wr_mask;
  logic [INT0_BITS-1:0]      int0_status;
  logic [INT0_BITS-1:0]      int0_mask;
  logic [INT1_BITS-1:0]      int1_status;
  logic [INT1_BITS-1:0]      int1_mask;

  rbus_node u_rbus_node (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_rbus           (i_rbus),
    .i_cfg_start_addr (i_cfg_start_addr),
    .i_cfg_end_addr   (i_cfg_end_addr),
    .i_locl_rsp       (locl_rsp),
    .o_rbus           (o_rbus),
    .o_locl_req       (locl_req)
  );

  support_regfile u_regfile (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_locl_req       (locl_req),
    .i_pipe_stat      (i_pipe_stat),
    .i_available      (available),
    .i_int0_status    (int0_status),
    .i_int0_mask      (int0_mask),
    .i_int1_status    (int1_status),
    .i_int1_mask      (int1_mask),
    .o_locl_rsp       (locl_rsp),
    .o_ctl_config     (o_ctl_config),
    .o_df_mux_sel     (o_df_mux_sel),
    .o_consumed_wr    (consumed_wr),
    .o_int0_rd_status (int0_rd_status),
    .o_int0_wr_status (int0_wr_status),
    .o_int0_wr_mask   (int0_wr_mask),
    .o_int1_rd_status (int1_rd_status),
    .o_int1_wr_status (int1_wr_status),
    .o_int1_wr_mask   (int1_wr_mask),
    .o_wr_data        (wr_data)
  );

  im_bank_ctrl u_im_bank_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_im_available (i_im_available),
    .i_consumed_wr  (consumed_wr),
    .i_wr_data      (wr_data[IM_BITS-1:0]),
    .o_available    (available),
    .o_im_consumed  (o_im_consumed)
  );

  // ##########################################################################
  // interrupt groups
  // ##########################################################################

  event_interrupt #(.N_INT_BITS(INT0_BITS)) u_int0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_event     (i_int0_event),
    .i_rd_status (int0_rd_status),
    .i_wr_status (int0_wr_status),
    .i_wr_mask   (int0_wr_mask),
    .i_wr_data   (wr_data[INT0_BITS-1:0]),
    .o_status    (int0_status),
    .o_mask      (int0_mask),
    .o_int       (o_int0)
  );

  event_interrupt #(.N_INT_BITS(INT1_BITS)) u_int1 (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_event     (i_int1_event),
    .i_rd_status (int1_rd_status),
    .i_wr_status (int1_wr_status),
    .i_wr_mask   (int1_wr_mask),
    .i_wr_data   (wr_data[INT1_BITS-1:0]),
    .o_status    (int1_status),
    .o_mask      (int1_mask),
    .o_int       (o_int1)
  );

endmodule

//--- tb/tb_cceip_support.sv
`timescale 1ns/1ps

module tb_cceip_support;
  import support_pkg::*;

  localparam logic [RBUS_ADDR_BITS-1:0] WIN_START = 20'h01000;
  localparam logic [RBUS_ADDR_BITS-1:0] WIN_END   = 20'h010ff;

  logic                      clk = 1'b0;
  logic                      rst_n;
  rbus_t                     i_rbus;
  im_banks_t                 i_im_available;
  logic [RBUS_DATA_BITS-1:0] i_pipe_stat;
  logic [INT0_BITS-1:0]      i_int0_event;
  logic [INT1_BITS-1:0]      i_int1_event;
  rbus_t                     o_rbus;
  im_banks_t                 o_im_consumed;
  logic [RBUS_DATA_BITS-1:0] o_ctl_config;
  logic [DF_MUX_BITS-1:0]    o_df_mux_sel;
  logic                      o_int0;
  logic                      o_int1;

  logic [31:0] op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] exp_q[$];
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  cceip_support cceip_support_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_rbus           (i_rbus),
    .i_cfg_start_addr (WIN_START),
    .i_cfg_end_addr   (WIN_END),
    .i_im_available   (i_im_available),
    .i_pipe_stat      (i_pipe_stat),
    .i_int0_event     (i_int0_event),
    .i_int1_event     (i_int1_event),
    .o_rbus           (o_rbus),
    .o_im_consumed    (o_im_consumed),
    .o_ctl_config     (o_ctl_config),
    .o_df_mux_sel     (o_df_mux_sel),
    .o_int0           (o_int0),
    .o_int1           (o_int1)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("simulation ran past %0d cycles without finishing", cycle_limit);
      $display("Regression failed");
      $fatal(1);
    end
  end

  // ##########################################################################
  // checks and expected responses
  // ##########################################################################

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %0t %s expected %0h got %0h", $time, name, expected, actual);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  // unmapped offsets and writes to read-only registers give err_ack.
  function automatic logic access_err(input logic is_wr, input logic [7:0] offset);
    case (offset)
      REG_BLKID_REVID, REG_IM_AVAILABLE, REG_PIPE_STAT: access_err = is_wr;
      REG_CTL, REG_DF_MUX_CTRL, REG_IM_CONSUMED:        access_err = 1'b0;
      REG_INT0_STATUS, REG_INT0_MASK:                    access_err = 1'b0;
      REG_INT1_STATUS, REG_INT1_MASK:                    access_err = 1'b0;
      default:                                           access_err = 1'b1;
    endcase
  endfunction

  task automatic window_access(input logic is_wr, input logic [31:0] addr,
                               input logic [31:0] data, input logic [31:0] exp_rd);
    logic               err_exp;
    logic [IM_BITS-1:0] cons_exp;
    int                 cyc;
    err_exp = access_err(is_wr, addr[LOCL_ADDR_BITS-1:0]);
    @(posedge clk);
    i_rbus <= '{addr: addr[RBUS_ADDR_BITS-1:0], wr_strb: is_wr, wr_data: data,
                rd_strb: !is_wr, rd_data: '0, ack: 1'b0, err_ack: 1'b0};
    @(posedge clk);
    i_rbus <= '0;
    cyc = 1;
    while (!(o_rbus.ack || o_rbus.err_ack)) begin
      cons_exp = '0;
      if (is_wr && addr[7:0] == REG_IM_CONSUMED && cyc == 3) begin
        cons_exp = data[IM_BITS-1:0];   // pulse one cycle after the strobe.
      end
      check_value("o_im_consumed", 128'(cons_exp), 128'(o_im_consumed));
      if (cyc == 8) begin
        $display("no ack or err_ack for access to %0h at %0t", addr, $time);
        $display("Regression failed");
        $fatal(1);
      end
      @(posedge clk);
      cyc++;
    end
    check_value("ack latency", 128'(3), 128'(cyc - 1));
    check_value("o_rbus.ack", 128'(!err_exp), 128'(o_rbus.ack));
    check_value("o_rbus.err_ack", 128'(err_exp), 128'(o_rbus.err_ack));
    check_value("o_im_consumed", 128'(0), 128'(o_im_consumed));
    if (!is_wr && !err_exp) begin
      check_value("o_rbus.rd_data", 128'(exp_rd), 128'(o_rbus.rd_data));
    end
  endtask

  task automatic pass_through(input logic is_wr, input logic [31:0] addr,
                              input logic [31:0] data, input logic [31:0] rd_data);
    rbus_t item;
    item = '{addr: addr[RBUS_ADDR_BITS-1:0], wr_strb: is_wr, wr_data: data,
             rd_strb: !is_wr, rd_data: rd_data, ack: 1'b0, err_ack: 1'b0};
    @(posedge clk);
    i_rbus <= item;
    @(posedge clk);
    i_rbus <= '0;
    @(posedge clk);
    check_value("o_rbus", 128'(item), 128'(o_rbus));   // one cycle later, untouched.
  endtask

  task automatic run_op(input int idx);
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expv;
    addr = addr_q[idx];
    data = data_q[idx];
    expv = exp_q[idx];
    case (op_q[idx])
      0, 1: begin
        if (addr[RBUS_ADDR_BITS-1:0] >= WIN_START && addr[RBUS_ADDR_BITS-1:0] <= WIN_END) begin
          window_access(op_q[idx] == 0, addr, data, expv);
        end else begin
          pass_through(op_q[idx] == 0, addr, data, expv);
        end
      end
      2: begin
        @(posedge clk);
        if (addr == 0) begin
          i_im_available <= im_banks_t'(data[IM_BITS-1:0]);
        end else begin
          i_pipe_stat <= data;
        end
        repeat (2) @(posedge clk);
      end
      3, 4: begin
        @(posedge clk);
        if (op_q[idx] == 3) begin
          i_int0_event <= data[INT0_BITS-1:0];
        end else begin
          i_int1_event <= data[INT1_BITS-1:0];
        end
        @(posedge clk);
        i_int0_event <= '0;
        i_int1_event <= '0;
      end
      5: begin
        repeat (2) @(posedge clk);   // let status and interrupt settle.
        case (addr)
          0:       check_value("o_ctl_config", 128'(expv), 128'(o_ctl_config));
          1:       check_value("o_df_mux_sel", 128'(expv), 128'(o_df_mux_sel));
          2:       check_value("o_int0", 128'(expv), 128'(o_int0));
          3:       check_value("o_int1", 128'(expv), 128'(o_int1));
          default: check_value("o_im_consumed", 128'(expv), 128'(o_im_consumed));
        endcase
      end
      default: begin
        $display("unknown operation code %0h in line %0d of the input file", op_q[idx], idx);
        $display("Regression failed");
        $fatal(1);
      end
    endcase
  endtask

  // ##########################################################################
  // main sequence
  // ##########################################################################

  initial begin
    int          fd;
    int          nread;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_exp;
    void'($urandom(32'hb427));
    rst_n          <= 1'b0;
    i_rbus         <= '0;
    i_im_available <= '0;
    i_pipe_stat    <= '0;
    i_int0_event   <= '0;
    i_int1_event   <= '0;
    fd = $fopen("tb/support_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb/support_input.txt");
      $display("Regression failed");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      nread = $fgets(line, fd);
      if (nread > 0 && $sscanf(line, "%h %h %h %h", f_op, f_addr, f_data, f_exp) == 4) begin
        op_q.push_back(f_op);
        addr_q.push_back(f_addr);
        data_q.push_back(f_data);
        exp_q.push_back(f_exp);
      end
    end
    $fclose(fd);
    cycle_limit = 20 * op_q.size() + 100;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    foreach (op_q[i]) begin
      repeat ($urandom % 4) @(posedge clk);   // 0 to 3 idle cycles.
      run_op(i);
    end
    repeat (2) @(posedge clk);
    $display("Regression passed");
    $finish;
  end

endmodule

//--- tb/support_input.txt
# columns: op addr data expect, all hex. op 0 write, 1 read, 2 set input, 3 event group 0,
# 4 event group 1, 5 check output. set input addr 0 is bank available, 1 is pipe status.
# check output addr 0 ctl, 1 mux select, 2 int0, 3 int1, 4 consumed. reads expect rd_data.
5 00000 00000000 00000000
5 00002 00000000 00000000
5 00004 00000000 00000000
1 01000 00000000 0c640001
0 01000 12345678 00000000
1 01030 00000000 00000000
0 02004 cafef00d 00000000
1 00ffc 00000000 5a5a5a5a
0 01004 a5a5c3c3 00000000
1 01004 00000000 a5a5c3c3
5 00000 00000000 a5a5c3c3
0 01008 0000000e 00000000
1 01008 00000000 0000000e
5 00001 00000000 00000002
2 00000 0002a5c3 00000000
1 0100c 00000000 0002a5c3
0 01010 0003f00f 00000000
2 00001 deadbeef 00000000
1 01014 00000000 deadbeef
3 00000 00000005 00000000
3 00000 00004100 00000000
1 01018 00000000 00004105
5 00002 00000000 00000000
0 0101c 00000100 00000000
5 00002 00000000 00000001
0 01018 00000100 00000000
1 01018 00000000 00004005
5 00002 00000000 00000000
4 00000 00000041 00000000
1 01020 00000000 00000041
0 01024 0000007f 00000000
5 00003 00000000 00000001
0 01020 00000041 00000000
5 00003 00000000 00000000

//--- verilog.f
logic/support_pkg.sv
logic/rbus_node.sv
logic/event_interrupt.sv
logic/im_bank_ctrl.sv
logic/support_regfile.sv
logic/cceip_support.sv
tb/tb_cceip_support.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -j 0 -f verilog.f --top-module tb_cceip_support -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf obj_dir
